/* tb/ctrl_patterns.txt */
# W byte_addr data | R byte_addr expected | S gen_status move_count | G half_move rank
# gen_status bits 6..0: idle moves_ready move_ready mate stalemate thrice_rep fifty_move
R 0000 00000000
R 0004 00000000
R 0008 00000000
R 000c 00000000
R 0010 00000000
R 0020 00000000
R 003c 00000000
R 021c 00000000
W 0000 ffffffff
R 0000 80000003
W 0004 000001a5
R 0004 000000a5
W 0008 fffffe5d
R 0008 0000005d
W 000c 000000ff
R 000c 0000007f
W 0010 00000003
R 0010 00000001
W 0020 76543210
W 0034 badc0ffe
W 003c 12345678
R 0020 76543210
R 0034 badc0ffe
G 7f 0
G 7f 5
G 7f 7
G 7f 3
S 7f 2a
R 0000 800001ff
R 021c 0000002a
S 41 11
R 0000 80000183
S 20 00
R 0000 80000007
W 021c 000000ff
W 0014 ffffffff
W 0040 ffffffff
W fffc ffffffff
R 0014 00000000
R 0040 00000000
R fffc 00000000
R 021c 00000000
R 0004 000000a5
R 0008 0000005d
R 000c 0000007f
R 0010 00000001
R 003c 12345678
G 7f 7
W 0000 00000000
R 0000 00000004

/* files.f */
design/chess_ctrl_pkg.sv
design/axi_lite_write.sv
design/axi_lite_read.sv
design/ctrl_regs.sv
design/chess_ctrl_top.sv
tb/tb_chess_ctrl.sv

/* Makefile */
TOP = tb_chess_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search sim.log for the pass message"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/tb_chess_ctrl.sv */
`timescale 1ns/1ps

module tb_chess_ctrl
   import chess_ctrl_pkg::*;
();

   localparam int timeout_cycles = 20;

   logic                  clk;
   logic                  rst;
   logic [addr_width-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;
   logic [data_width-1:0] wdata;
   logic                  wvalid;
   logic                  wready;
   logic [1:0]            bresp;
   logic                  bvalid;
   logic                  bready;
   logic [addr_width-1:0] araddr;
   logic                  arvalid;
   logic                  arready;
   logic [data_width-1:0] rdata;
   logic [1:0]            rresp;
   logic                  rvalid;
   logic                  rready;
   gen_cmd_t              gen_cmd;
   logic [7:0]            move_index;
   logic [6:0]            half_move;
   gen_status_t           gen_status;
   logic [7:0]            move_count;

   int          fd;
   int          n;
   int          i;
   string       line;
   byte         op;
   logic [31:0] f1;
   logic [31:0] f2;
   logic [31:0] rank_shadow [0:7]; // Last word written to each rank
   logic [8:0]  pos_shadow;
   logic [7:0]  move_index_shadow;
   logic [3:0]  flag_shadow;       // new_board_valid, clear_moves, capture_moves, soft_reset

   chess_ctrl_top u_chess_ctrl_top (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic abort_run();
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
         abort_run();
      end
   endtask

   task automatic stalled(input string what);
      $display("Timeout waiting for %s", what);
      abort_run();
   endtask

   task automatic axi_write(input logic [15:0] addr, input logic [31:0] data);
      int cycles;
      int delay;
      @(negedge clk);
      awaddr = addr;
      wdata = data;
      awvalid = 1'b1;
      wvalid = 1'b1;
      cycles = 0;
      do
      begin
         @(posedge clk);
         cycles++;
         if (cycles > timeout_cycles) stalled("the AW/W handshake");
      end
      while (!(awready && wready));
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
         if (cycles > timeout_cycles) stalled("bvalid");
      end
      while (!bvalid);
      compare("bresp", 32'(bresp), 32'd0);
      delay = $urandom % 4;
      // Valids stay up to tempt a second write
      repeat (delay)
      begin
         compare("awready", 32'(awready), 32'd0);
         @(negedge clk);
         compare("bvalid", 32'(bvalid), 32'd1);
      end
      awvalid = 1'b0;
      wvalid = 1'b0;
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
      compare("bvalid", 32'(bvalid), 32'd0);
   endtask

   task automatic axi_read(input logic [15:0] addr, input logic [31:0] expected);
      int          cycles;
      int          delay;
      logic [31:0] held;
      @(negedge clk);
      araddr = addr;
      arvalid = 1'b1;
      cycles = 0;
      do
      begin
         @(posedge clk);
         cycles++;
         if (cycles > timeout_cycles) stalled("the AR handshake");
      end
      while (!arready);
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
         if (cycles > timeout_cycles) stalled("rvalid");
      end
      while (!rvalid);
      held = rdata;
      compare("rdata", held, expected);
      compare("rresp", 32'(rresp), 32'd0);
      araddr = addr ^ 16'h0004; // A second request waits behind R
      delay = $urandom % 4;
      repeat (delay)
      begin
         compare("arready", 32'(arready), 32'd0);
         @(negedge clk);
         compare("rvalid", 32'(rvalid), 32'd1);
         compare("rdata", rdata, held); // Held under back-pressure
      end
      arvalid = 1'b0;
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
      compare("rvalid", 32'(rvalid), 32'd0);
   endtask

   initial
   begin
      void'($urandom(32'hc404_ec54));
      rst = 1'b1;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      gen_status = '0;
      move_count = '0;
      pos_shadow = '0;
      move_index_shadow = '0;
      flag_shadow = '0;
      for (i = 0; i < 8; i++) rank_shadow[i] = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      compare("bvalid", 32'(bvalid), 32'd0);
      compare("rvalid", 32'(rvalid), 32'd0);
      compare("arready", 32'(arready), 32'd1);
      compare("gen_cmd flags and pos", 32'(gen_cmd[$bits(gen_cmd_t)-1:board_width]), 32'd0);
      for (i = 0; i < 8; i++) compare("gen_cmd.board", gen_cmd.board[i*32 +: 32], 32'd0);
      compare("move_index", 32'(move_index), 32'd0);
      compare("half_move", 32'(half_move), 32'd0);

      fd = $fopen("tb/ctrl_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open tb/ctrl_patterns.txt");
         abort_run();
      end
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#") continue; // Blank or column notes
         op = line[0];
         n = $sscanf(line.substr(1, line.len() - 1), "%h %h", f1, f2);
         if (n != 2)
         begin
            $display("Malformed pattern line: %s", line);
            abort_run();
         end
         case (op)
            "W":
            begin
               axi_write(f1[15:0], f2);
               if (f1[15:2] >= 14'd8 && f1[15:2] <= 14'd15) rank_shadow[f1[4:2]] = f2;
               if (f1[15:2] == 14'd2) pos_shadow = f2[8:0];
               if (f1[15:2] == 14'd1) move_index_shadow = f2[7:0];
               if (f1[15:2] == 14'd0) flag_shadow = {f2[0], f2[1], flag_shadow[1], f2[31]};
               if (f1[15:2] == 14'd4) flag_shadow[1] = f2[0];
            end
            "R": axi_read(f1[15:0], f2);
            "S":
            begin
               @(negedge clk);
               gen_status = gen_status_t'(f1[6:0]);
               move_count = f2[7:0];
            end
            "G":
            begin
               compare("half_move", 32'(half_move), f1);
               compare("gen_cmd.board rank", gen_cmd.board[f2[2:0]*32 +: 32],
                       rank_shadow[f2[2:0]]);
               compare("gen_cmd.pos", 32'(gen_cmd.pos), 32'(pos_shadow));
               compare("move_index", 32'(move_index), 32'(move_index_shadow));
               compare("gen_cmd flags",
                       32'({gen_cmd.new_board_valid, gen_cmd.clear_moves,
                            gen_cmd.capture_moves, gen_cmd.soft_reset}),
                       32'(flag_shadow));
            end
            default:
            begin
               $display("Unknown opcode in pattern line: %s", line);
               abort_run();
            end
         endcase
      end
      $fclose(fd);
      $display("Everything OK");
      $finish;
   end

endmodule

/* design/chess_ctrl_top.sv */
`timescale 1ns/1ps

module chess_ctrl_top
   import chess_ctrl_pkg::*;
#(
   parameter int move_index_width = 8,
   parameter int half_move_width = 7
)
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [addr_width-1:0]       awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [data_width-1:0]       wdata,
   input  logic                        wvalid,
   output logic                        wready,
   output logic [1:0]                  bresp,
   output logic                        bvalid,
   input  logic                        bready,
   input  logic [addr_width-1:0]       araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [data_width-1:0]       rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready,
   output gen_cmd_t                    gen_cmd,
   output logic [move_index_width-1:0] move_index,
   output logic [half_move_width-1:0]  half_move,
   input  gen_status_t                 gen_status,
   input  logic [move_index_width-1:0] move_count
);

   wr_req_t wr_req;

   axi_lite_write u_write (
      .clk     (clk),
      .rst     (rst),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .wr_req  (wr_req)
   );

   ctrl_regs #(
      .move_index_width (move_index_width),
      .half_move_width  (half_move_width)
   ) u_regs (
      .clk        (clk),
      .rst        (rst),
      .wr_req     (wr_req),
      .gen_cmd    (gen_cmd),
      .move_index (move_index),
      .half_move  (half_move)
   );

   // Readback sees the register outputs directly
   axi_lite_read #(
      .move_index_width (move_index_width),
      .half_move_width  (half_move_width)
   ) u_read (
      .clk        (clk),
      .rst        (rst),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rvalid     (rvalid),
      .rready     (rready),
      .gen_cmd    (gen_cmd),
      .move_index (move_index),
      .half_move  (half_move),
      .gen_status (gen_status),
      .move_count (move_count)
   );

endmodule

/* design/ctrl_regs.sv */
`timescale 1ns/1ps

module ctrl_regs
   import chess_ctrl_pkg::*;
#(
   parameter int move_index_width = 8,
   parameter int half_move_width = 7
)
(
   input  logic                        clk,
   input  logic                        rst,
   input  wr_req_t                     wr_req,
   output gen_cmd_t                    gen_cmd,
   output logic [move_index_width-1:0] move_index,
   output logic [half_move_width-1:0]  half_move
);

   logic [2:0] rank_sel;

   // Ranks sit at word indices 8 to 15
   assign rank_sel = wr_req.index[2:0];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         gen_cmd <= '0;
         move_index <= '0;
         half_move <= '0;
      end
      else if (wr_req.valid)
      begin
         case (wr_req.index)
            REG_CTRL:
            begin
               gen_cmd.new_board_valid <= wr_req.data[0];
               gen_cmd.clear_moves <= wr_req.data[1];
               gen_cmd.soft_reset <= wr_req.data[31];
            end
            REG_MOVE_INDEX:
            begin
               move_index <= wr_req.data[move_index_width-1:0];
            end
            REG_POS_STATE:
            begin
               gen_cmd.pos <= pos_state_t'(wr_req.data[$bits(pos_state_t)-1:0]);
            end
            REG_HALF_MOVE:
            begin
               half_move <= wr_req.data[half_move_width-1:0];
            end
            REG_CAPTURE:
            begin
               gen_cmd.capture_moves <= wr_req.data[0];
            end
            REG_BOARD_RANK0, REG_BOARD_RANK1, REG_BOARD_RANK2, REG_BOARD_RANK3,
            REG_BOARD_RANK4, REG_BOARD_RANK5, REG_BOARD_RANK6, REG_BOARD_RANK7:
            begin
               gen_cmd.board[rank_sel*rank_width +: rank_width] <= wr_req.data;
            end
            default:
            begin
               // Move count and unmapped words are ignored
            end
         endcase
      end
   end

   a_index_known: assert property (@(posedge clk) disable iff (rst)
      wr_req.valid |-> !$isunknown(wr_req.index));

endmodule

/* design/axi_lite_read.sv */
`timescale 1ns/1ps

module axi_lite_read
   import chess_ctrl_pkg::*;
#(
   parameter int move_index_width = 8,
   parameter int half_move_width = 7
)
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [addr_width-1:0]       araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [data_width-1:0]       rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready,
   input  gen_cmd_t                    gen_cmd,
   input  logic [move_index_width-1:0] move_index,
   input  logic [half_move_width-1:0]  half_move,
   input  gen_status_t                 gen_status,
   input  logic [move_index_width-1:0] move_count
);

   rd_state_e                 state;
   logic [word_idx_width-1:0] rd_idx;
   logic [data_width-1:0]     rd_value;
   logic                      xfer;

   assign rd_idx = araddr[addr_width-1:2];
   assign arready = (state == RD_IDLE); // Low while R is pending
   assign xfer = arready && arvalid;
   assign rvalid = (state == RD_RESP);
   assign rresp = resp_okay;

   always_comb
   begin
      rd_value = '0;
      case (rd_idx)
         REG_CTRL:
         begin
            rd_value[0] = gen_cmd.new_board_valid;
            rd_value[1] = gen_cmd.clear_moves;
            rd_value[2] = gen_status.moves_ready;
            rd_value[3] = gen_status.move_ready;
            rd_value[4] = gen_status.stalemate;
            rd_value[5] = gen_status.mate;
            rd_value[6] = gen_status.thrice_rep;
            rd_value[7] = gen_status.idle;
            rd_value[8] = gen_status.fifty_move;
            rd_value[31] = gen_cmd.soft_reset;
         end
         REG_MOVE_INDEX: rd_value[move_index_width-1:0] = move_index;
         REG_POS_STATE: rd_value[$bits(pos_state_t)-1:0] = gen_cmd.pos;
         REG_HALF_MOVE: rd_value[half_move_width-1:0] = half_move;
         REG_CAPTURE: rd_value[0] = gen_cmd.capture_moves;
         REG_BOARD_RANK0, REG_BOARD_RANK1, REG_BOARD_RANK2, REG_BOARD_RANK3,
         REG_BOARD_RANK4, REG_BOARD_RANK5, REG_BOARD_RANK6, REG_BOARD_RANK7:
            rd_value = gen_cmd.board[rd_idx[2:0]*rank_width +: rank_width];
         REG_MOVE_COUNT: rd_value[move_index_width-1:0] = move_count;
         default: rd_value = '0; // Unmapped
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= RD_IDLE;
      end
      else
      begin
         case (state)
            RD_IDLE: if (xfer) state <= RD_RESP;
            RD_RESP: if (rready) state <= RD_IDLE;
            default: state <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (xfer)
      begin
         rdata <= rd_value;
      end
   end

   a_rdata_hold: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* design/axi_lite_write.sv */
`timescale 1ns/1ps

module axi_lite_write
   import chess_ctrl_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic [addr_width-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [data_width-1:0] wdata,
   input  logic                  wvalid,
   output logic                  wready,
   output logic [1:0]            bresp,
   output logic                  bvalid,
   input  logic                  bready,
   output wr_req_t               wr_req
);

   wr_state_e state;
   logic      xfer;

   // Address and data are taken only as a pair
   assign xfer = (state == WR_IDLE) && awvalid && wvalid;
   assign awready = xfer;
   assign wready = xfer;
   assign bvalid = (state == WR_RESP);
   assign bresp = resp_okay;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= WR_IDLE;
      end
      else
      begin
         case (state)
            WR_IDLE: if (xfer) state <= WR_RESP;
            WR_RESP: if (bready) state <= WR_IDLE;
            default: state <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_req.valid <= 1'b0;
      end
      else
      begin
         wr_req.valid <= xfer; // One cycle pulse
         if (xfer)
         begin
            wr_req.index <= awaddr[addr_width-1:2];
            wr_req.data <= wdata;
         end
      end
   end

   a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid);

endmodule

/* design/chess_ctrl_pkg.sv */
package chess_ctrl_pkg;

   localparam int data_width = 32;
   localparam int addr_width = 16;
   localparam int word_idx_width = addr_width - 2; // Byte address to word index
   localparam int rank_width = 32;                 // Eight 4-bit squares
   localparam int num_ranks = 8;
   localparam int board_width = rank_width * num_ranks;

   localparam logic [1:0] resp_okay = 2'b00;

   // Word index map over byte address bits 15:2
   typedef enum logic [word_idx_width-1:0] {
      REG_CTRL        = 14'd0,
      REG_MOVE_INDEX  = 14'd1,
      REG_POS_STATE   = 14'd2,
      REG_HALF_MOVE   = 14'd3,
      REG_CAPTURE     = 14'd4,
      REG_BOARD_RANK0 = 14'd8,
      REG_BOARD_RANK1 = 14'd9,
      REG_BOARD_RANK2 = 14'd10,
      REG_BOARD_RANK3 = 14'd11,
      REG_BOARD_RANK4 = 14'd12,
      REG_BOARD_RANK5 = 14'd13,
      REG_BOARD_RANK6 = 14'd14,
      REG_BOARD_RANK7 = 14'd15,
      REG_MOVE_COUNT  = 14'd135   // Read only
   } reg_addr_e;

   typedef struct packed {
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;
   } pos_state_t;

   typedef struct packed {
      logic                   new_board_valid;
      logic                   clear_moves;
      logic                   capture_moves;
      logic                   soft_reset;
      pos_state_t             pos;
      logic [board_width-1:0] board;     // Rank n at bits 32n+31:32n
   } gen_cmd_t;

   typedef struct packed {
      logic idle;
      logic moves_ready;
      logic move_ready;
      logic mate;
      logic stalemate;
      logic thrice_rep;
      logic fifty_move;
   } gen_status_t;

   typedef struct packed {
      logic                      valid;
      logic [word_idx_width-1:0] index;
      logic [data_width-1:0]     data;
   } wr_req_t;

   typedef enum logic {
      WR_IDLE,
      WR_RESP
   } wr_state_e;

   typedef enum logic {
      RD_IDLE,
      RD_RESP
   } rd_state_e;

endpackage
